//--- sim.f
recovery_pkg.sv
recovery_csr_if.sv
recovery_tx_if.sv
recovery_cmd_fsm.sv
recovery_csr_file.sv
recovery_resp_tx.sv
recovery_executor.sv
tb_recovery_executor.sv

//--- Bender.yml
package:
  name: recovery_executor

sources:
  - recovery_pkg.sv
  - recovery_csr_if.sv
  - recovery_tx_if.sv
  - recovery_cmd_fsm.sv
  - recovery_csr_file.sv
  - recovery_resp_tx.sv
  - recovery_executor.sv
  - target: test
    files:
      - tb_recovery_executor.sv

//--- tb_recovery_executor.sv
// Random-stimulus testbench for the recovery command executor with a register model
`timescale 1ns/1ps

module tb_recovery_executor;

  localparam int unsigned FifoDepth  = 8;
  localparam int unsigned CmdTimeout = 400;

  logic                clk_i;
  logic                rst_ni;
  logic                cmd_valid_i;
  logic                cmd_is_rd_i;
  logic [7:0]          cmd_cmd_i;
  recovery_pkg::len_t  cmd_len_i;
  logic                cmd_error_i;
  logic                cmd_done_o;
  logic                tti_rx_rreq_o;
  logic                tti_rx_rack_i;
  recovery_pkg::word_t tti_rx_rdata_i;
  logic                res_valid_o;
  logic                res_ready_i;
  recovery_pkg::len_t  res_len_o;
  logic                res_dvalid_o;
  logic                res_dready_i;
  logic [7:0]          res_data_o;
  logic                res_dlast_o;
  logic                indirect_rx_wvalid_o;
  recovery_pkg::word_t indirect_rx_wdata_o;
  logic                indirect_rx_clr_o;
  logic                rx_queue_clr_o;
  logic                payload_available_o;
  logic                image_activated_o;
  logic                recovery_mode_enabled_i;

  integer seed;

  // Register model
  recovery_pkg::word_t m_dev_reset;
  recovery_pkg::word_t m_rec_ctrl;
  recovery_pkg::word_t m_fifo_ctrl0;
  recovery_pkg::word_t m_fifo_ctrl1;
  int unsigned         m_widx;
  logic                m_payload;

  // Observed traffic of the current command
  recovery_pkg::word_t acked[$];
  recovery_pkg::word_t planned[$];
  recovery_pkg::word_t fifo_seen[$];
  logic [7:0]          rx_bytes[$];
  logic                rx_lasts[$];
  recovery_pkg::len_t  rreq_cnt, valid_cnt, hdr_cnt, qclr_cnt, fclr_cnt, hdr_len;

  recovery_executor #(
    .IndirectFifoDepth (FifoDepth)
  ) dut (
    .clk_i                   (clk_i),
    .rst_ni                  (rst_ni),
    .cmd_valid_i             (cmd_valid_i),
    .cmd_is_rd_i             (cmd_is_rd_i),
    .cmd_cmd_i               (cmd_cmd_i),
    .cmd_len_i               (cmd_len_i),
    .cmd_error_i             (cmd_error_i),
    .cmd_done_o              (cmd_done_o),
    .tti_rx_rreq_o           (tti_rx_rreq_o),
    .tti_rx_rack_i           (tti_rx_rack_i),
    .tti_rx_rdata_i          (tti_rx_rdata_i),
    .res_valid_o             (res_valid_o),
    .res_ready_i             (res_ready_i),
    .res_len_o               (res_len_o),
    .res_dvalid_o            (res_dvalid_o),
    .res_dready_i            (res_dready_i),
    .res_data_o              (res_data_o),
    .res_dlast_o             (res_dlast_o),
    .indirect_rx_wvalid_o    (indirect_rx_wvalid_o),
    .indirect_rx_wdata_o     (indirect_rx_wdata_o),
    .indirect_rx_clr_o       (indirect_rx_clr_o),
    .rx_queue_clr_o          (rx_queue_clr_o),
    .payload_available_o     (payload_available_o),
    .image_activated_o       (image_activated_o),
    .recovery_mode_enabled_i (recovery_mode_enabled_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1, "Simulation stopped after an error");
  endtask

  task automatic check_word(input recovery_pkg::word_t got, input recovery_pkg::word_t exp,
                            input string what);
    if (got !== exp) begin
      stop_on_error($sformatf("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
    if (got !== exp) begin
      stop_on_error($sformatf("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_len(input recovery_pkg::len_t got, input recovery_pkg::len_t exp,
                           input string what);
    if (got !== exp) begin
      stop_on_error($sformatf("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_on_error($sformatf("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  // Ready is high about three cycles out of four
  function automatic logic ready_draw();
    return ($unsigned($random(seed)) % 4) != 0;
  endfunction

  // Byte length of each readable block
  function automatic recovery_pkg::len_t block_len(input logic [7:0] code);
    case (code)
      recovery_pkg::CMD_DEVICE_RESET:         return 16'd3;
      recovery_pkg::CMD_RECOVERY_CTRL:        return 16'd3;
      recovery_pkg::CMD_INDIRECT_FIFO_CTRL:   return 16'd6;
      recovery_pkg::CMD_INDIRECT_FIFO_STATUS: return 16'd8;
      default:                                return 16'd0;
    endcase
  endfunction

  function automatic recovery_pkg::word_t model_word(input logic [7:0] code, input int idx);
    case (code)
      recovery_pkg::CMD_DEVICE_RESET:         return m_dev_reset;
      recovery_pkg::CMD_RECOVERY_CTRL:        return m_rec_ctrl;
      recovery_pkg::CMD_INDIRECT_FIFO_CTRL:   return (idx == 0) ? m_fifo_ctrl0 : m_fifo_ctrl1;
      recovery_pkg::CMD_INDIRECT_FIFO_STATUS: return (idx == 0) ? m_widx : FifoDepth;
      default:                                return '0;
    endcase
  endfunction

  // RX queue answers each rreq after 0 to 3 idle cycles
  initial begin : rx_responder
    int unsigned         gap;
    recovery_pkg::word_t w;
    forever begin
      @(negedge clk_i);
      if (rst_ni && tti_rx_rreq_o) begin
        gap = $unsigned($random(seed)) % 4;
        repeat (gap) @(posedge clk_i);
        @(posedge clk_i);
        if (planned.size() > 0) w = planned.pop_front();
        else w = $random(seed);
        #2;
        tti_rx_rack_i  = 1'b1;
        tti_rx_rdata_i = w;
        acked.push_back(w);
        @(posedge clk_i);
        #2;
        tti_rx_rack_i  = 1'b0;
        tti_rx_rdata_i = '0;
      end
    end
  end

  // Monitor samples DUT outputs on the falling edge
  always @(negedge clk_i) begin
    if (tti_rx_rreq_o) rreq_cnt++;
    if (res_valid_o) valid_cnt++;
    if (res_valid_o) hdr_len = res_len_o;
    if (res_valid_o && res_ready_i) hdr_cnt++;
    if (rx_queue_clr_o) qclr_cnt++;
    if (indirect_rx_clr_o) fclr_cnt++;
    if (indirect_rx_wvalid_o) fifo_seen.push_back(indirect_rx_wdata_o);
    if (res_dvalid_o && res_dready_i) begin
      rx_bytes.push_back(res_data_o);
      rx_lasts.push_back(res_dlast_o);
    end
  end

  // Holds the command until cmd_done_o, with random response stalls
  task automatic run_cmd(input logic is_rd, input logic [7:0] code,
                         input recovery_pkg::len_t len, input logic err);
    int unsigned cycles;
    logic        done;
    cycles = 0;
    done   = 1'b0;
    acked.delete();
    fifo_seen.delete();
    rx_bytes.delete();
    rx_lasts.delete();
    rreq_cnt  = '0;
    valid_cnt = '0;
    hdr_cnt   = '0;
    qclr_cnt  = '0;
    fclr_cnt  = '0;
    hdr_len   = '0;
    @(posedge clk_i);
    #2;
    cmd_valid_i  = 1'b1;
    cmd_is_rd_i  = is_rd;
    cmd_cmd_i    = code;
    cmd_len_i    = len;
    cmd_error_i  = err;
    res_ready_i  = ready_draw();
    res_dready_i = ready_draw();
    while (!done) begin
      @(negedge clk_i);
      done = cmd_done_o;
      cycles++;
      if (!done && cycles > CmdTimeout) begin
        stop_on_error($sformatf("Timeout: command %0d did not finish within %0d cycles",
                                code, CmdTimeout));
      end
      @(posedge clk_i);
      #2;
      res_ready_i  = done ? 1'b0 : ready_draw();
      res_dready_i = done ? 1'b0 : ready_draw();
      if (done) begin
        cmd_valid_i = 1'b0;
        cmd_error_i = 1'b0;
      end
    end
  endtask

  task automatic read_block(input logic [7:0] code);
    recovery_pkg::len_t  n;
    recovery_pkg::word_t w;
    int                  i;
    n = block_len(code);
    run_cmd(1'b1, code, n, 1'b0);
    check_len(hdr_len, n, "res_len_o");
    check_len(hdr_cnt, 16'd1, "header handshakes");
    check_len(recovery_pkg::len_t'(rx_bytes.size()), n, "response byte count");
    check_len(rreq_cnt, 16'd0, "rreq pulses during read");
    for (i = 0; i < int'(n); i++) begin
      w = model_word(code, i / 4);
      check_byte(rx_bytes[i], w[8*(i%4) +: 8], "response byte");
      check_flag(rx_lasts[i], i == int'(n) - 1, "res_dlast_o");
    end
  endtask

  task automatic write_block(input logic [7:0] code, input recovery_pkg::len_t len);
    int unsigned         nwords;
    int                  i;
    logic                expect_clr;
    recovery_pkg::word_t w;
    nwords     = (int'(len) + 3) / 4;
    expect_clr = 1'b0;
    run_cmd(1'b0, code, len, 1'b0);
    check_len(recovery_pkg::len_t'(acked.size()), nwords, "acknowledged words");
    check_len(rreq_cnt, nwords, "rreq pulses");
    check_len(qclr_cnt, 16'd0, "rx_queue_clr_o pulses");
    if (code == recovery_pkg::CMD_INDIRECT_FIFO_DATA) begin
      check_len(recovery_pkg::len_t'(fifo_seen.size()), nwords, "FIFO writes");
      m_payload = 1'b1;
    end else begin
      check_len(recovery_pkg::len_t'(fifo_seen.size()), 16'd0, "FIFO writes");
    end
    // Words past the last register word are dropped
    for (i = 0; i < int'(nwords); i++) begin
      w = acked[i];
      case (code)
        recovery_pkg::CMD_DEVICE_RESET:  if (i == 0) m_dev_reset = w;
        recovery_pkg::CMD_RECOVERY_CTRL: if (i == 0) m_rec_ctrl = w;
        recovery_pkg::CMD_INDIRECT_FIFO_CTRL: begin
          if (i == 0) begin
            m_fifo_ctrl0 = w;
            if (w[15:8] == 8'd1) begin
              expect_clr = 1'b1;
              m_widx     = 0;
              m_payload  = 1'b0;
            end
          end else if (i == 1) begin
            m_fifo_ctrl1 = w;
          end
        end
        recovery_pkg::CMD_INDIRECT_FIFO_DATA: begin
          check_word(fifo_seen[i], w, "indirect_rx_wdata_o");
          m_widx = (m_widx + 1) % FifoDepth;
        end
        default: ;
      endcase
    end
    check_len(fclr_cnt, expect_clr ? 16'd1 : 16'd0, "indirect_rx_clr_o pulses");
    check_flag(payload_available_o, m_payload, "payload_available_o");
    check_flag(image_activated_o, m_rec_ctrl[23:16] == 8'h0F, "image_activated_o");
  endtask

  task automatic reject_cmd(input logic is_rd, input logic [7:0] code,
                            input recovery_pkg::len_t len, input logic err);
    run_cmd(is_rd, code, len, err);
    check_len(qclr_cnt, 16'd1, "rx_queue_clr_o pulses");
    check_len(rreq_cnt, 16'd0, "rreq pulses");
    check_len(valid_cnt, 16'd0, "res_valid_o cycles");
    check_len(recovery_pkg::len_t'(fifo_seen.size()), 16'd0, "FIFO writes");
  endtask

  initial begin : main
    int unsigned        pick;
    logic [7:0]         code;
    recovery_pkg::len_t len;
    seed                    = 32'ha068d2d1;
    rst_ni                  = 1'b0;
    cmd_valid_i             = 1'b0;
    cmd_is_rd_i             = 1'b0;
    cmd_cmd_i               = '0;
    cmd_len_i               = '0;
    cmd_error_i             = 1'b0;
    tti_rx_rack_i           = 1'b0;
    tti_rx_rdata_i          = '0;
    res_ready_i             = 1'b0;
    res_dready_i            = 1'b0;
    recovery_mode_enabled_i = 1'b0;
    m_dev_reset             = '0;
    m_rec_ctrl              = '0;
    m_fifo_ctrl0            = '0;
    m_fifo_ctrl1            = '0;
    m_widx                  = 0;
    m_payload               = 1'b0;
    repeat (3) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_flag(cmd_done_o, 1'b0, "cmd_done_o after reset");
    check_flag(tti_rx_rreq_o, 1'b0, "tti_rx_rreq_o after reset");
    check_flag(res_valid_o, 1'b0, "res_valid_o after reset");
    check_flag(res_dvalid_o, 1'b0, "res_dvalid_o after reset");
    check_flag(indirect_rx_wvalid_o, 1'b0, "indirect_rx_wvalid_o after reset");
    check_flag(indirect_rx_clr_o, 1'b0, "indirect_rx_clr_o after reset");
    check_flag(rx_queue_clr_o, 1'b0, "rx_queue_clr_o after reset");
    check_flag(payload_available_o, 1'b0, "payload_available_o after reset");

    // Random register writes, each read back
    @(posedge clk_i);
    #2;
    recovery_mode_enabled_i = 1'b1;
    repeat (16) begin
      pick = $unsigned($random(seed)) % 3;
      code = (pick == 0) ? recovery_pkg::CMD_DEVICE_RESET :
             (pick == 1) ? recovery_pkg::CMD_RECOVERY_CTRL :
                           recovery_pkg::CMD_INDIRECT_FIFO_CTRL;
      len  = $unsigned($random(seed)) % 13;
      write_block(code, len);
      read_block(code);
    end

    // Zero-length write ends without a queue read
    write_block(recovery_pkg::CMD_DEVICE_RESET, 16'd0);
    read_block(recovery_pkg::CMD_DEVICE_RESET);

    // Activation code in byte 2, then a value without it
    planned.push_back(32'h5A0F_3C11);
    write_block(recovery_pkg::CMD_RECOVERY_CTRL, 16'd4);
    planned.push_back(32'h0010_0000);
    write_block(recovery_pkg::CMD_RECOVERY_CTRL, 16'd3);

    // Enough payload words to wrap the write index
    repeat (10) begin
      len = $unsigned($random(seed)) % 25;
      write_block(recovery_pkg::CMD_INDIRECT_FIFO_DATA, len);
      read_block(recovery_pkg::CMD_INDIRECT_FIFO_STATUS);
    end

    // Clear only shows from a nonzero write index
    if (m_widx == 0) begin
      write_block(recovery_pkg::CMD_INDIRECT_FIFO_DATA, 16'd4);
    end
    planned.push_back(32'h0000_01C3);
    write_block(recovery_pkg::CMD_INDIRECT_FIFO_CTRL, 16'd8);
    read_block(recovery_pkg::CMD_INDIRECT_FIFO_STATUS);
    read_block(recovery_pkg::CMD_INDIRECT_FIFO_CTRL);

    reject_cmd(1'b0, 8'd40, 16'd8, 1'b0);
    reject_cmd(1'b1, 8'd99, 16'd4, 1'b0);
    reject_cmd(1'b0, recovery_pkg::CMD_DEVICE_RESET, 16'd4, 1'b1);
    reject_cmd(1'b1, recovery_pkg::CMD_RECOVERY_CTRL, 16'd3, 1'b1);
    recovery_mode_enabled_i = 1'b0;
    reject_cmd(1'b0, recovery_pkg::CMD_INDIRECT_FIFO_CTRL, 16'd8, 1'b0);
    reject_cmd(1'b1, recovery_pkg::CMD_INDIRECT_FIFO_STATUS, 16'd8, 1'b0);
    reject_cmd(1'b0, recovery_pkg::CMD_INDIRECT_FIFO_DATA, 16'd12, 1'b0);
    read_block(recovery_pkg::CMD_DEVICE_RESET);
    read_block(recovery_pkg::CMD_RECOVERY_CTRL);
    recovery_mode_enabled_i = 1'b1;
    read_block(recovery_pkg::CMD_INDIRECT_FIFO_CTRL);
    read_block(recovery_pkg::CMD_INDIRECT_FIFO_STATUS);
    check_flag(payload_available_o, m_payload, "payload_available_o after rejects");
    check_flag(image_activated_o, m_rec_ctrl[23:16] == 8'h0F, "image_activated_o at end");

    $display("RESULT: PASS");
    $finish;
  end

endmodule

//--- recovery_executor.sv
// Recovery command executor top: command FSM, register block and response serializer
`timescale 1ns/1ps

module recovery_executor #(
  parameter int unsigned IndirectFifoDepth = 64
) (
  input  logic                clk_i,
  input  logic                rst_ni,

  // Decoded command
  input  logic                cmd_valid_i,
  input  logic                cmd_is_rd_i,
  input  logic [7:0]          cmd_cmd_i,
  input  recovery_pkg::len_t  cmd_len_i,
  input  logic                cmd_error_i,
  output logic                cmd_done_o,

  // RX data queue
  output logic                tti_rx_rreq_o,
  input  logic                tti_rx_rack_i,
  input  recovery_pkg::word_t tti_rx_rdata_i,

  // Response header
  output logic                res_valid_o,
  input  logic                res_ready_i,
  output recovery_pkg::len_t  res_len_o,

  // Response data
  output logic                res_dvalid_o,
  input  logic                res_dready_i,
  output logic [7:0]          res_data_o,
  output logic                res_dlast_o,

  // Indirect FIFO write port
  output logic                indirect_rx_wvalid_o,
  output recovery_pkg::word_t indirect_rx_wdata_o,
  output logic                indirect_rx_clr_o,

  // Status and mode
  output logic                rx_queue_clr_o,
  output logic                payload_available_o,
  output logic                image_activated_o,
  input  logic                recovery_mode_enabled_i
);

  recovery_csr_if csr_bus ();
  recovery_tx_if  tx_bus ();

  recovery_cmd_fsm u_cmd_fsm (
    .clk_i                   (clk_i),
    .rst_ni                  (rst_ni),
    .cmd_valid_i             (cmd_valid_i),
    .cmd_is_rd_i             (cmd_is_rd_i),
    .cmd_cmd_i               (cmd_cmd_i),
    .cmd_len_i               (cmd_len_i),
    .cmd_error_i             (cmd_error_i),
    .recovery_mode_enabled_i (recovery_mode_enabled_i),
    .tti_rx_rack_i           (tti_rx_rack_i),
    .tti_rx_rdata_i          (tti_rx_rdata_i),
    .cmd_done_o              (cmd_done_o),
    .tti_rx_rreq_o           (tti_rx_rreq_o),
    .res_valid_o             (res_valid_o),
    .rx_queue_clr_o          (rx_queue_clr_o),
    .res_len_o               (res_len_o),
    .res_ready_i             (res_ready_i),
    .csr                     (csr_bus.fsm),
    .tx                      (tx_bus.fsm)
  );

  recovery_csr_file #(
    .IndirectFifoDepth (IndirectFifoDepth)
  ) u_csr_file (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .csr                  (csr_bus.csr),
    .indirect_rx_wvalid_o (indirect_rx_wvalid_o),
    .indirect_rx_wdata_o  (indirect_rx_wdata_o),
    .indirect_rx_clr_o    (indirect_rx_clr_o),
    .payload_available_o  (payload_available_o),
    .image_activated_o    (image_activated_o)
  );

  // Serializer reads the word the FSM currently selects
  recovery_resp_tx u_resp_tx (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .tx           (tx_bus.tx),
    .word_i       (csr_bus.rdata),
    .res_dvalid_o (res_dvalid_o),
    .res_dlast_o  (res_dlast_o),
    .res_data_o   (res_data_o),
    .res_dready_i (res_dready_i)
  );

endmodule

//--- recovery_resp_tx.sv
// Response serializer: sends register words as a counted byte stream, LSB first
`timescale 1ns/1ps

module recovery_resp_tx (
  input  logic                clk_i,
  input  logic                rst_ni,
  recovery_tx_if.tx           tx,
  input  recovery_pkg::word_t word_i,
  output logic                res_dvalid_o,
  output logic                res_dlast_o,
  output logic [7:0]          res_data_o,
  input  logic                res_dready_i
);

  logic               dvalid_q;
  recovery_pkg::len_t remain_q;
  logic [1:0]         lane_q;
  logic               fire;
  logic               last;

  assign fire = dvalid_q && res_dready_i;
  assign last = (remain_q == 16'd1);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dvalid_q <= 1'b0;
      remain_q <= '0;
      lane_q   <= '0;
    end else if (tx.start) begin
      dvalid_q <= 1'b1;
      remain_q <= tx.len;
      lane_q   <= '0;
    end else if (fire) begin
      remain_q <= remain_q - 16'd1;
      lane_q   <= lane_q + 2'd1;
      if (last) begin
        dvalid_q <= 1'b0;
      end
    end
  end

  // Byte lane of the word currently selected
  assign res_data_o   = word_i[{lane_q, 3'b000} +: 8];
  assign res_dvalid_o = dvalid_q;
  assign res_dlast_o  = dvalid_q && last;

  // Selector moves on as the fourth byte leaves
  assign tx.word_next = fire && (lane_q == 2'd3);
  assign tx.done      = fire && last;

endmodule

//--- recovery_csr_file.sv
// Recovery register block with read mux, indirect FIFO write index and status flags
`timescale 1ns/1ps

module recovery_csr_file #(
  parameter int unsigned IndirectFifoDepth = 64
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  recovery_csr_if.csr         csr,
  output logic                indirect_rx_wvalid_o,
  output recovery_pkg::word_t indirect_rx_wdata_o,
  output logic                indirect_rx_clr_o,
  output logic                payload_available_o,
  output logic                image_activated_o
);

  localparam int unsigned IdxW = (IndirectFifoDepth > 1) ? $clog2(IndirectFifoDepth) : 1;

  recovery_pkg::word_t device_reset_q;
  recovery_pkg::word_t recovery_ctrl_q;
  recovery_pkg::word_t fifo_ctrl_0_q;
  recovery_pkg::word_t fifo_ctrl_1_q;
  logic [IdxW-1:0]     wr_idx_q;
  logic                payload_q;
  logic                fifo_clr;

  // Clear request in byte 1 of FIFO_CTRL word 0
  assign fifo_clr = csr.wr_en && (csr.sel == recovery_pkg::SEL_FIFO_CTRL_0) &&
                    (csr.wdata[15:8] == recovery_pkg::FifoClearCode);

  // Writable registers, status words and SEL_NONE drop the word
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      device_reset_q  <= '0;
      recovery_ctrl_q <= '0;
      fifo_ctrl_0_q   <= '0;
      fifo_ctrl_1_q   <= '0;
    end else if (csr.wr_en) begin
      case (csr.sel)
        recovery_pkg::SEL_DEVICE_RESET:  device_reset_q  <= csr.wdata;
        recovery_pkg::SEL_RECOVERY_CTRL: recovery_ctrl_q <= csr.wdata;
        recovery_pkg::SEL_FIFO_CTRL_0:   fifo_ctrl_0_q   <= csr.wdata;
        recovery_pkg::SEL_FIFO_CTRL_1:   fifo_ctrl_1_q   <= csr.wdata;
        default: ;
      endcase
    end
  end

  // Write index wraps at the FIFO depth
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_idx_q <= '0;
    end else if (fifo_clr) begin
      wr_idx_q <= '0;
    end else if (csr.fifo_wr) begin
      if (32'(wr_idx_q) == IndirectFifoDepth - 1) begin
        wr_idx_q <= '0;
      end else begin
        wr_idx_q <= wr_idx_q + 1'b1;
      end
    end
  end

  // Set when a FIFO data write starts, dropped by a FIFO clear
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      payload_q <= 1'b0;
    end else if (fifo_clr) begin
      payload_q <= 1'b0;
    end else if (csr.data_start) begin
      payload_q <= 1'b1;
    end
  end

  always_comb begin
    case (csr.sel)
      recovery_pkg::SEL_DEVICE_RESET:  csr.rdata = device_reset_q;
      recovery_pkg::SEL_RECOVERY_CTRL: csr.rdata = recovery_ctrl_q;
      recovery_pkg::SEL_FIFO_CTRL_0:   csr.rdata = fifo_ctrl_0_q;
      recovery_pkg::SEL_FIFO_CTRL_1:   csr.rdata = fifo_ctrl_1_q;
      recovery_pkg::SEL_FIFO_STATUS_0: csr.rdata = recovery_pkg::word_t'(wr_idx_q);
      recovery_pkg::SEL_FIFO_STATUS_1: csr.rdata = recovery_pkg::word_t'(IndirectFifoDepth);
      default:                         csr.rdata = '0;
    endcase
  end

  assign indirect_rx_wvalid_o = csr.fifo_wr;
  assign indirect_rx_wdata_o  = csr.wdata;
  assign indirect_rx_clr_o    = fifo_clr;
  assign payload_available_o  = payload_q;
  assign image_activated_o    = (recovery_ctrl_q[23:16] == recovery_pkg::ImageActivateCode);

endmodule

//--- recovery_cmd_fsm.sv
// Recovery command FSM: validates commands, drives RX reads and steps the register selector
`timescale 1ns/1ps

module recovery_cmd_fsm (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                cmd_valid_i,
  input  logic                cmd_is_rd_i,
  input  logic [7:0]          cmd_cmd_i,
  input  recovery_pkg::len_t  cmd_len_i,
  input  logic                cmd_error_i,
  input  logic                recovery_mode_enabled_i,
  input  logic                tti_rx_rack_i,
  input  recovery_pkg::word_t tti_rx_rdata_i,
  output logic                cmd_done_o,
  output logic                tti_rx_rreq_o,
  output logic                res_valid_o,
  output logic                rx_queue_clr_o,
  output recovery_pkg::len_t  res_len_o,
  input  logic                res_ready_i,
  recovery_csr_if.fsm         csr,
  recovery_tx_if.fsm          tx
);

  typedef enum logic [2:0] {
    Idle,
    CsrWrite,
    FifoWrite,
    CsrRead,
    CsrReadData,
    Error,
    Done
  } state_e;

  state_e                 state_q, state_d;
  recovery_pkg::csr_sel_e sel_q, sel_last_q;
  recovery_pkg::csr_sel_e first_sel, last_sel;
  recovery_pkg::len_t     len_q, blk_len;
  logic [14:0]            words_q;
  logic                   known;
  logic                   reject;
  logic                   accept;
  logic                   is_data;
  logic                   advance;
  logic                   rreq_q, rreq_d;

  // First and last register word of each block, plus its read length
  always_comb begin
    known     = 1'b1;
    first_sel = recovery_pkg::SEL_NONE;
    last_sel  = recovery_pkg::SEL_NONE;
    blk_len   = '0;
    case (cmd_cmd_i)
      recovery_pkg::CMD_DEVICE_RESET: begin
        first_sel = recovery_pkg::SEL_DEVICE_RESET;
        last_sel  = recovery_pkg::SEL_DEVICE_RESET;
        blk_len   = recovery_pkg::DeviceResetLen;
      end
      recovery_pkg::CMD_RECOVERY_CTRL: begin
        first_sel = recovery_pkg::SEL_RECOVERY_CTRL;
        last_sel  = recovery_pkg::SEL_RECOVERY_CTRL;
        blk_len   = recovery_pkg::RecoveryCtrlLen;
      end
      recovery_pkg::CMD_INDIRECT_FIFO_CTRL: begin
        first_sel = recovery_pkg::SEL_FIFO_CTRL_0;
        last_sel  = recovery_pkg::SEL_FIFO_CTRL_1;
        blk_len   = recovery_pkg::FifoCtrlLen;
      end
      recovery_pkg::CMD_INDIRECT_FIFO_STATUS: begin
        first_sel = recovery_pkg::SEL_FIFO_STATUS_0;
        last_sel  = recovery_pkg::SEL_FIFO_STATUS_1;
        blk_len   = recovery_pkg::FifoStatusLen;
      end
      recovery_pkg::CMD_INDIRECT_FIFO_DATA: begin
        first_sel = recovery_pkg::SEL_FIFO_DATA;
        last_sel  = recovery_pkg::SEL_FIFO_DATA;
      end
      default: known = 1'b0;
    endcase
  end

  assign is_data = (cmd_cmd_i == recovery_pkg::CMD_INDIRECT_FIFO_DATA);
  assign accept  = (state_q == Idle) && cmd_valid_i;

  // FIFO data has no read path, so a read of it is rejected too
  assign reject = cmd_error_i || !known ||
                  (!recovery_mode_enabled_i && (cmd_cmd_i >= recovery_pkg::RecoveryOnlyFirst)) ||
                  (cmd_is_rd_i && is_data);

  always_comb begin
    state_d = state_q;
    rreq_d  = 1'b0;
    case (state_q)
      Idle: begin
        if (accept) begin
          if (reject) begin
            state_d = Error;
          end else if (cmd_is_rd_i) begin
            state_d = CsrRead;
          end else if (cmd_len_i == '0) begin
            state_d = Done;
          end else begin
            state_d = is_data ? FifoWrite : CsrWrite;
            rreq_d  = 1'b1;
          end
        end
      end
      CsrWrite, FifoWrite: begin
        if (tti_rx_rack_i) begin
          if (words_q == 15'd1) begin
            state_d = Done;
          end else begin
            rreq_d = 1'b1;
          end
        end
      end
      CsrRead: begin
        if (res_ready_i) begin
          state_d = CsrReadData;
        end
      end
      CsrReadData: begin
        if (tx.done) begin
          state_d = Done;
        end
      end
      Error:   state_d = Done;
      default: state_d = Idle;
    endcase
  end

  // Step to the next register word on each written or sent word
  assign advance = ((state_q == CsrWrite) && tti_rx_rack_i) || tx.word_next;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= Idle;
      rreq_q     <= 1'b0;
      sel_q      <= recovery_pkg::SEL_NONE;
      sel_last_q <= recovery_pkg::SEL_NONE;
      len_q      <= '0;
      words_q    <= '0;
    end else begin
      state_q <= state_d;
      rreq_q  <= rreq_d;
      if (accept) begin
        sel_q      <= first_sel;
        sel_last_q <= last_sel;
        len_q      <= blk_len;
        // Byte length to words, rounded up
        words_q    <= 15'(cmd_len_i[15:2]) + 15'(|cmd_len_i[1:0]);
      end else begin
        if (advance) begin
          if ((sel_q == sel_last_q) || (sel_q == recovery_pkg::SEL_NONE)) begin
            sel_q <= recovery_pkg::SEL_NONE;
          end else begin
            sel_q <= recovery_pkg::csr_sel_e'(sel_q + 3'd1);
          end
        end
        if (((state_q == CsrWrite) || (state_q == FifoWrite)) && tti_rx_rack_i) begin
          words_q <= words_q - 15'd1;
        end
      end
    end
  end

  assign cmd_done_o     = (state_q == Done);
  assign rx_queue_clr_o = (state_q == Error);
  assign res_valid_o    = (state_q == CsrRead);
  assign res_len_o      = len_q;
  assign tti_rx_rreq_o  = rreq_q;

  assign csr.sel        = sel_q;
  assign csr.wr_en      = (state_q == CsrWrite) && tti_rx_rack_i;
  assign csr.fifo_wr    = (state_q == FifoWrite) && tti_rx_rack_i;
  assign csr.wdata      = tti_rx_rdata_i;
  assign csr.data_start = accept && !reject && !cmd_is_rd_i && is_data;

  assign tx.start = (state_q == CsrRead) && res_ready_i;
  assign tx.len   = len_q;

endmodule

//--- recovery_tx_if.sv
// Response control bus between the command FSM and the byte serializer
`timescale 1ns/1ps

interface recovery_tx_if;

  logic               start;
  recovery_pkg::len_t len;
  logic               word_next;
  logic               done;

  modport fsm (
    output start,
    output len,
    input  word_next,
    input  done
  );

  modport tx (
    input  start,
    input  len,
    output word_next,
    output done
  );

endinterface

//--- recovery_csr_if.sv
// Register access bus between the command FSM and the recovery register block
`timescale 1ns/1ps

interface recovery_csr_if;

  recovery_pkg::csr_sel_e sel;
  logic                   wr_en;
  recovery_pkg::word_t    wdata;
  logic                   fifo_wr;
  logic                   data_start;
  recovery_pkg::word_t    rdata;

  modport fsm (
    output sel,
    output wr_en,
    output wdata,
    output fifo_wr,
    output data_start,
    input  rdata
  );

  modport csr (
    input  sel,
    input  wr_en,
    input  wdata,
    input  fifo_wr,
    input  data_start,
    output rdata
  );

endinterface

//--- recovery_pkg.sv
// Recovery executor shared definitions: command codes, register selector, lengths and types
package recovery_pkg;

  // Recovery command codes kept by the executor
  typedef enum logic [7:0] {
    CMD_DEVICE_RESET         = 8'd37,
    CMD_RECOVERY_CTRL        = 8'd38,
    CMD_INDIRECT_FIFO_CTRL   = 8'd45,
    CMD_INDIRECT_FIFO_STATUS = 8'd46,
    CMD_INDIRECT_FIFO_DATA   = 8'd47
  } cmd_e;

  // Codes from here upwards are only legal in recovery mode
  localparam logic [7:0] RecoveryOnlyFirst = 8'd45;

  // One entry per register word
  typedef enum logic [2:0] {
    SEL_DEVICE_RESET,
    SEL_RECOVERY_CTRL,
    SEL_FIFO_CTRL_0,
    SEL_FIFO_CTRL_1,
    // Write index
    SEL_FIFO_STATUS_0,
    // FIFO size
    SEL_FIFO_STATUS_1,
    SEL_FIFO_DATA,
    SEL_NONE
  } csr_sel_e;

  typedef logic [31:0] word_t;
  typedef logic [15:0] len_t;

  // Block lengths in bytes
  localparam len_t DeviceResetLen  = 16'd3;
  localparam len_t RecoveryCtrlLen = 16'd3;
  localparam len_t FifoCtrlLen     = 16'd6;
  localparam len_t FifoStatusLen   = 16'd8;

  // Byte 1 of FIFO_CTRL word 0
  localparam logic [7:0] FifoClearCode = 8'd1;

  // Byte 2 of RECOVERY_CTRL
  localparam logic [7:0] ImageActivateCode = 8'h0F;

endpackage
